//--- aud_consts.svh
/* Aux audio constants */

`ifndef AUD_CONSTS_SVH
`define AUD_CONSTS_SVH

//////////////////////////////////////////////////
// Widths
//////////////////////////////////////////////////

`define AUD_SAMPLE_BITS 16   // One sample word
`define AUD_ADDR_BITS   23   // Word address of memory port

//////////////////////////////////////////////////
// Sizes and timing
//////////////////////////////////////////////////

`define AUD_FIFO_DEPTH  8    // FIFO entries, also initial credits
`define AUD_RING_BITS   16   // Default ring size, log2 of words
`define AUD_PERIOD      643  // Clocks per stereo sample

//////////////////////////////////////////////////
// Register map
//////////////////////////////////////////////////

`define AUD_REG_CTRL    0    // Enable in bit 0, clears underrun
`define AUD_REG_BASE    1    // Ring base, upper address bits

`endif

//--- aud_pkg.sv
/* Aux audio types */

`default_nettype none

`include "aud_consts.svh"

package aud_pkg;

  typedef logic signed [`AUD_SAMPLE_BITS-1:0] sample_t;  // Two's complement sample

  typedef struct packed {
    sample_t left;   // Upper half
    sample_t right;
  } stereo_t;

  typedef logic [`AUD_ADDR_BITS-1:0] mem_addr_t;  // Word address

  typedef struct packed {
    logic      valid;  // Always accepted by memory
    mem_addr_t addr;
  } mem_req_t;

  typedef struct packed {
    logic                        valid;  // In request order
    logic [`AUD_SAMPLE_BITS-1:0] data;   // Raw memory word
  } mem_rsp_t;

  typedef struct packed {
    logic                     valid;  // One-cycle strobe
    logic                     addr;   // CTRL or BASE
    logic [`AUD_ADDR_BITS-1:0] data;
  } reg_wr_t;

endpackage

`default_nettype wire

//--- aud_regs.sv
/* Aux audio registers */

`default_nettype none

`include "aud_consts.svh"

module aud_regs #(
  parameter int RING_BITS = `AUD_RING_BITS  // Offset bits below base
) (
  input  wire logic                              clk_114,
  input  wire logic                              reset,
  input  wire aud_pkg::reg_wr_t                  reg_wr,        // Host write strobe
  input  wire logic                              underrun_set,  // Pulse from pacer
  output logic                                   enable,
  output logic [`AUD_ADDR_BITS-RING_BITS-1:0]    base,
  output logic                                   underrun       // Sticky
);

  localparam int BASE_BITS = `AUD_ADDR_BITS - RING_BITS;

  logic ctrl_wr;  // Write hits CTRL
  logic base_wr;  // Write hits BASE

  assign ctrl_wr = reg_wr.valid && (reg_wr.addr == 1'(`AUD_REG_CTRL));
  assign base_wr = reg_wr.valid && (reg_wr.addr == 1'(`AUD_REG_BASE));

  //////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////

  always_ff @(posedge clk_114) begin
    if (reset) begin
      enable   <= 1'b0;
      base     <= '0;
      underrun <= 1'b0;
    end else begin
      if (ctrl_wr) enable <= reg_wr.data[0];          // Bit 0 only
      if (base_wr) base <= reg_wr.data[BASE_BITS-1:0];  // Low bits of data
      if (underrun_set) begin
        underrun <= 1'b1;    // Set wins over clear
      end else if (ctrl_wr) begin
        underrun <= 1'b0;    // Any CTRL write acks
      end
    end
  end

endmodule

`default_nettype wire

//--- aud_fetch.sv
/* Ring buffer fetcher */

`default_nettype none

`include "aud_consts.svh"

module aud_fetch #(
  parameter int RING_BITS = `AUD_RING_BITS  // Ring size, log2 of words
) (
  input  wire logic                              clk_114,
  input  wire logic                              reset,
  input  wire logic                              enable,
  input  wire logic [`AUD_ADDR_BITS-RING_BITS-1:0] base,
  input  wire aud_pkg::mem_rsp_t                 mem_rsp,
  input  wire logic                              pop,        // Only while not_empty
  output aud_pkg::mem_req_t                      mem_req,
  output aud_pkg::sample_t                       head,       // Oldest FIFO word
  output logic                                   not_empty,
  output logic                                   aux_half    // Half being filled
);

  import aud_pkg::*;

  localparam int DEPTH = `AUD_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [RING_BITS-1:0] offset;            // Offset of next request
  logic [CNT_W-1:0]     credits;           // Free slots not yet requested
  logic [CNT_W-1:0]     outstanding;       // Requests awaiting response
  logic [CNT_W-1:0]     outstanding_next;
  logic [CNT_W-1:0]     count;             // Words held
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic                 drain;             // Was flushing last cycle
  logic                 flush;
  logic                 issue;
  logic                 push;
  sample_t              fifo [DEPTH];

  // Stay in flush after re-enable until stale responses are gone
  assign flush = !enable || (drain && (outstanding != '0));
  assign issue = !flush && (credits != '0);  // One credit per request
  assign push  = mem_rsp.valid && !flush;    // Discard while flushing

  assign outstanding_next = outstanding + CNT_W'(issue) - CNT_W'(mem_rsp.valid);

  assign mem_req.valid = issue;
  assign mem_req.addr  = {base, offset};     // Base above ring offset

  assign head      = fifo[rd_ptr];
  assign not_empty = (count != '0);
  assign aux_half  = offset[RING_BITS-1];

  //////////////////////////////////////////////////
  // Credits, ring offset and FIFO pointers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_114) begin
    if (reset) begin
      offset      <= '0;
      credits     <= CNT_W'(DEPTH);  // Full credit
      outstanding <= '0;
      count       <= '0;
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      drain       <= 1'b0;
    end else begin
      drain       <= flush;
      outstanding <= outstanding_next;
      if (flush) begin
        offset <= '0;    // Restart ring
        count  <= '0;
        wr_ptr <= '0;
        rd_ptr <= '0;
        if (outstanding_next == '0) credits <= CNT_W'(DEPTH);  // All discarded
      end else begin
        if (issue) offset <= offset + 1'b1;  // Wraps at ring size
        if (push) wr_ptr <= wr_ptr + 1'b1;
        if (pop) rd_ptr <= rd_ptr + 1'b1;
        count   <= count + CNT_W'(push) - CNT_W'(pop);
        credits <= credits - CNT_W'(issue) + CNT_W'(pop);  // Pop frees a slot
      end
    end
  end

  // Sample storage
  always_ff @(posedge clk_114) begin
    if (push) fifo[wr_ptr] <= sample_t'(mem_rsp.data);
  end

endmodule

`default_nettype wire

//--- aud_pacer.sv
/* Sample pacer */

`default_nettype none

`include "aud_consts.svh"

module aud_pacer #(
  parameter int PERIOD = `AUD_PERIOD  // Clocks per stereo sample
) (
  input  wire logic             clk_114,
  input  wire logic             reset,
  input  wire aud_pkg::sample_t head,          // FIFO head word
  input  wire logic             not_empty,
  output logic                  pop,
  output aud_pkg::stereo_t      aux,           // Paced aux samples
  output logic                  underrun_set   // Pop due on empty FIFO
);

  import aud_pkg::*;

  localparam int CNT_W = $clog2(PERIOD);

  logic [CNT_W-1:0] cnt;      // Period counter
  logic             tick;     // Left phase
  logic             tick_d;   // Right phase
  logic             due;
  sample_t          swapped;

  assign tick    = (cnt == CNT_W'(PERIOD - 1));
  assign due     = tick || tick_d;
  assign pop     = due && not_empty;
  assign underrun_set = due && !not_empty;
  assign swapped = {head[7:0], head[15:8]};  // Memory words are byte swapped

  //////////////////////////////////////////////////
  // Tick, phase and lane registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_114) begin
    if (reset) begin
      cnt    <= '0;
      tick_d <= 1'b0;
      aux    <= '0;
    end else begin
      cnt    <= tick ? '0 : cnt + 1'b1;
      tick_d <= tick;
      if (pop) begin
        if (tick) begin
          aux.left <= swapped;
        end else begin
          aux.right <= swapped;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- aud_mixer.sv
/* Saturating stereo mixer */

`default_nettype none

`include "aud_consts.svh"

module aud_mixer (
  input  wire logic             clk_114,
  input  wire logic             reset,
  input  wire aud_pkg::stereo_t native,  // Chipset audio
  input  wire aud_pkg::stereo_t aux,     // Streamed audio
  output aud_pkg::stereo_t      mixed
);

  import aud_pkg::*;

  localparam int W = `AUD_SAMPLE_BITS;

  // Signed add, clamped to the sample range
  function automatic sample_t sat_add(input sample_t a, input sample_t b);
    logic signed [W:0] sum;
    sum = a + b;                          // One guard bit
    if (sum[W] != sum[W-1]) begin         // Overflow
      return sum[W] ? {1'b1, {(W-1){1'b0}}} : {1'b0, {(W-1){1'b1}}};
    end
    return sum[W-1:0];
  endfunction

  always_ff @(posedge clk_114) begin
    if (reset) begin
      mixed <= '0;
    end else begin
      mixed.left  <= sat_add(native.left, aux.left);
      mixed.right <= sat_add(native.right, aux.right);
    end
  end

endmodule

`default_nettype wire

//--- sd_dac.sv
/* Stereo sigma-delta DAC */

`default_nettype none

`include "aud_consts.svh"

module sd_dac (
  input  wire logic             clk_114,
  input  wire logic             reset,
  input  wire aud_pkg::stereo_t mixed,
  output logic                  audio_l,
  output logic                  audio_r
);

  import aud_pkg::*;

  localparam int W = `AUD_SAMPLE_BITS;

  sample_t        lane [2];   // 0 left, 1 right
  logic [W-1:0]   acc  [2];   // Modulator accumulators
  logic [1:0]     bits;       // Registered carries

  assign lane[0] = mixed.left;
  assign lane[1] = mixed.right;
  assign audio_l = bits[0];
  assign audio_r = bits[1];

  // Offset binary via inverted sign, carry out is the pulse density
  always_ff @(posedge clk_114) begin
    if (reset) begin
      acc[0] <= '0;
      acc[1] <= '0;
      bits   <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        {bits[i], acc[i]} <= acc[i] + {~lane[i][W-1], lane[i][W-2:0]};
      end
    end
  end

endmodule

`default_nettype wire

//--- aud_top.sv
/* Aux audio path top level */

`default_nettype none

`include "aud_consts.svh"

module aud_top #(
  parameter int RING_BITS = `AUD_RING_BITS,  // Ring size, log2 of words
  parameter int PERIOD    = `AUD_PERIOD       // Clocks per stereo sample
) (
  input  wire logic              clk_114,
  input  wire logic              reset,
  input  wire aud_pkg::reg_wr_t  reg_wr,
  input  wire aud_pkg::mem_rsp_t mem_rsp,
  input  wire aud_pkg::stereo_t  native,
  output aud_pkg::mem_req_t      mem_req,
  output logic                   audio_l,
  output logic                   audio_r,
  output logic                   aux_half,
  output logic                   underrun
);

  import aud_pkg::*;

  logic                              enable;
  logic [`AUD_ADDR_BITS-RING_BITS-1:0] base;
  logic                              underrun_set;
  sample_t                           head;
  logic                              not_empty;
  logic                              pop;
  stereo_t                           aux;     // Paced stream samples
  stereo_t                           mixed;   // To DAC

  aud_regs #(.RING_BITS(RING_BITS)) aud_regs_i (
    .clk_114, .reset, .reg_wr, .underrun_set, .enable, .base, .underrun
  );

  aud_fetch #(.RING_BITS(RING_BITS)) aud_fetch_i (
    .clk_114, .reset, .enable, .base, .mem_rsp, .pop,
    .mem_req, .head, .not_empty, .aux_half
  );

  aud_pacer #(.PERIOD(PERIOD)) aud_pacer_i (
    .clk_114, .reset, .head, .not_empty, .pop, .aux, .underrun_set
  );

  aud_mixer aud_mixer_i (.clk_114, .reset, .native, .aux, .mixed);

  sd_dac sd_dac_i (.clk_114, .reset, .mixed, .audio_l, .audio_r);

endmodule

`default_nettype wire

//--- tb_mem_model.sv
/* Memory responder model */

`default_nettype none

module tb_mem_model (
  input  wire logic              clk_114,
  input  wire logic              reset,
  input  wire logic              stall,      // Hold every response
  input  wire logic [15:0]       even_word,  // Data at even addresses
  input  wire aud_pkg::mem_req_t mem_req,
  output aud_pkg::mem_rsp_t      mem_rsp
);

  timeunit 1ns;
  timeprecision 100ps;

  import aud_pkg::*;

  mem_addr_t   addr_q [$];  // Pending requests, oldest first
  int          due_q  [$];  // Earliest sampling edge per response
  mem_addr_t   addr;
  int          edge_no;
  logic [31:0] rng;

  // LCG step for response latency
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Works 1 ns after each edge, oldest response goes out before new request is queued
  initial begin
    mem_rsp = '0;
    edge_no = 0;
    rng     = 32'd77;  // Seed
    forever begin
      @(posedge clk_114);
      #1;
      edge_no++;
      mem_rsp = '0;
      if (reset) begin
        addr_q.delete();
        due_q.delete();
      end else begin
        if (!stall && addr_q.size() != 0 && due_q[0] <= edge_no + 1) begin
          addr = addr_q.pop_front();
          void'(due_q.pop_front());
          mem_rsp.valid = 1'b1;
          mem_rsp.data  = addr[0] ? 16'h7856 : even_word;  // Parity decides word
        end
        if (mem_req.valid) begin  // Issued at next edge
          rng = lcg_next(rng);
          addr_q.push_back(mem_req.addr);
          due_q.push_back(edge_no + 1 + 1 + int'(rng[23:16] % 6));  // 1 to 6 cycles
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_aud_top.sv
/* Aux audio path testbench */

`default_nettype none

`include "aud_consts.svh"

module tb_aud_top;

  timeunit 1ns;
  timeprecision 100ps;

  import aud_pkg::*;

  localparam int RING   = 4;   // 16-word ring
  localparam int PERIOD = 40;
  localparam int BASE_W = `AUD_ADDR_BITS - RING;
  localparam logic [BASE_W-1:0] BASE = 19'h2a5c3;

  logic clk_114;
  logic reset;
  logic stall;
  logic [15:0] even_word;
  logic audio_l;
  logic audio_r;
  logic aux_half;
  logic underrun;
  reg_wr_t  reg_wr;
  mem_req_t mem_req;
  mem_rsp_t mem_rsp;
  stereo_t  native;

  logic              en_model;    // Enable as the DUT holds it
  logic [BASE_W-1:0] base_model;
  logic [RING-1:0]   exp_offset;  // Offset of next request
  int                pend;        // Requests minus responses
  int                phase;       // Pacer period position
  logic              ctrl_wr;

  assign ctrl_wr = reg_wr.valid && (reg_wr.addr == 1'(`AUD_REG_CTRL));

  aud_top #(.RING_BITS(RING), .PERIOD(PERIOD)) aud_top_i (
    .clk_114, .reset, .reg_wr, .mem_rsp, .native,
    .mem_req, .audio_l, .audio_r, .aux_half, .underrun
  );

  tb_mem_model mem_i (.clk_114, .reset, .stall, .even_word, .mem_req, .mem_rsp);

  initial begin
    clk_114 = 1'b0;
    forever #4 clk_114 = ~clk_114;  // 8 ns period
  end

  //////////////////////////////////////////////////
  // Reference state
  //////////////////////////////////////////////////

  always @(posedge clk_114) begin
    if (reset) begin
      en_model   <= 1'b0;
      base_model <= '0;
      exp_offset <= '0;
      pend       <= 0;
      phase      <= 0;
    end else begin
      if (ctrl_wr) en_model <= reg_wr.data[0];  // Visible next cycle
      if (reg_wr.valid && reg_wr.addr == 1'(`AUD_REG_BASE)) begin
        base_model <= reg_wr.data[BASE_W-1:0];
      end
      if (!en_model) exp_offset <= '0;          // Ring restarts
      else if (mem_req.valid) exp_offset <= exp_offset + 1'b1;
      pend  <= pend + int'(mem_req.valid) - int'(mem_rsp.valid);
      phase <= (phase == PERIOD - 1) ? 0 : phase + 1;
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  assert property (@(posedge clk_114) disable iff (reset) !en_model |-> !mem_req.valid)
    else fail_check("addr_order", 0, $sampled(mem_req.valid));
  assert property (@(posedge clk_114) disable iff (reset)
      mem_req.valid |-> mem_req.addr == {base_model, exp_offset})
    else fail_check("addr_order", $sampled({base_model, exp_offset}), $sampled(mem_req.addr));
  assert property (@(posedge clk_114) disable iff (reset) pend <= `AUD_FIFO_DEPTH)
    else fail_check("credit_limit", `AUD_FIFO_DEPTH, $sampled(pend));
  assert property (@(posedge clk_114) disable iff (reset) aux_half == exp_offset[RING-1])
    else fail_check("half_flag", $sampled(exp_offset[RING-1]), $sampled(aux_half));
  assert property (@(posedge clk_114) disable iff (reset)
      $past(underrun) && !$past(ctrl_wr) |-> underrun)  // Sticky until CTRL write
    else fail_check("underrun", 1, $sampled(underrun));

  task automatic fail_check(input string test, input logic [31:0] expected,
                            input logic [31:0] actual);
    $display("error %s expected 0x%0h actual 0x%0h", test, expected, actual);
    $display(">>> FAIL");
    $fatal(1, "stopping at first failed check");
  endtask

  task automatic fail_timeout(input string what);
    $display("timed out waiting for %s", what);
    $display(">>> FAIL");
    $fatal(1, "stopping at timeout");
  endtask

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  task automatic cycle();
    @(posedge clk_114);
    #1;  // Drive and sample off the edge
  endtask

  task automatic write_reg(input logic addr, input logic [`AUD_ADDR_BITS-1:0] data);
    reg_wr.valid = 1'b1;
    reg_wr.addr  = addr;
    reg_wr.data  = data;
    cycle();
    reg_wr = '0;
  endtask

  // Write early in the period, far from both pops
  task automatic write_at_phase(input logic addr, input logic [`AUD_ADDR_BITS-1:0] data);
    int n;
    n = 0;
    while (phase != 3) begin
      if (n == PERIOD + 2) fail_timeout("pacer phase");
      cycle();
      n++;
    end
    write_reg(addr, data);
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (pend != 0) begin
      if (n == 100) fail_timeout("outstanding responses");
      cycle();
      n++;
    end
  endtask

  task automatic wait_underrun(input logic level, input int limit, input string what);
    int n;
    n = 0;
    while (underrun !== level) begin
      if (n == limit) fail_timeout(what);
      cycle();
      n++;
    end
  endtask

  task automatic count_ones(output int ones_l, output int ones_r);
    ones_l = 0;
    ones_r = 0;
    repeat (65536) begin
      ones_l += int'(audio_l);
      ones_r += int'(audio_r);
      cycle();
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    int ones_l;
    int ones_r;
    int reqs;
    reset     = 1'b1;
    reg_wr    = '0;
    native    = '0;
    stall     = 1'b0;
    even_word = 16'h3412;
    repeat (10) @(posedge clk_114);
    #1 reset = 1'b0;

    write_reg(1'(`AUD_REG_BASE), 23'(BASE));
    repeat (50) cycle();                        // Disabled, bus must stay idle
    write_at_phase(1'(`AUD_REG_CTRL), 23'd1);
    repeat (300) cycle();                       // Several ring wraps
    write_reg(1'(`AUD_REG_CTRL), 23'd0);
    wait_drained();
    repeat (20) cycle();
    write_at_phase(1'(`AUD_REG_CTRL), 23'd1);  // Restart at offset 0

    repeat (2000) cycle();
    count_ones(ones_l, ones_r);
    assert (ones_l == 32'h1234 + 32'h8000)
      else fail_check("dac_density", 32'h1234 + 32'h8000, ones_l);
    assert (ones_r == 32'h5678 + 32'h8000)
      else fail_check("dac_density", 32'h5678 + 32'h8000, ones_r);

    native.left = 16'sh7000;                    // Clamps high
    repeat (2000) cycle();
    count_ones(ones_l, ones_r);
    assert (ones_l == 65535) else fail_check("saturation", 65535, ones_l);
    native.left = -16'sh7fff;
    even_word   = 16'h0080;                     // Most negative after swap
    repeat (2000) cycle();
    count_ones(ones_l, ones_r);
    assert (ones_l == 0) else fail_check("saturation", 0, ones_l);

    native    = '0;
    even_word = 16'h3412;
    write_reg(1'(`AUD_REG_CTRL), 23'd0);
    wait_drained();
    stall = 1'b1;
    write_at_phase(1'(`AUD_REG_CTRL), 23'd1);
    reqs = 0;
    repeat (100) begin
      reqs += int'(mem_req.valid);
      cycle();
    end
    assert (reqs == `AUD_FIFO_DEPTH) else fail_check("credit_limit", `AUD_FIFO_DEPTH, reqs);

    write_at_phase(1'(`AUD_REG_CTRL), 23'd1);  // Clear, FIFO stays empty
    wait_underrun(1'b0, 3, "underrun to clear");
    wait_underrun(1'b1, PERIOD + 10, "underrun to rise");
    repeat (2 * PERIOD) cycle();
    write_at_phase(1'(`AUD_REG_CTRL), 23'd1);
    wait_underrun(1'b0, 3, "underrun to clear");

    stall = 1'b0;
    wait_drained();
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
aud_pkg.sv
aud_regs.sv
aud_fetch.sv
aud_pacer.sv
aud_mixer.sv
sd_dac.sv
aud_top.sv
tb_mem_model.sv
tb_aud_top.sv

//--- Bender.yml
package:
  name: aux_audio

export_include_dirs:
  - .

sources:
  - files:
      - aud_pkg.sv
      - aud_regs.sv
      - aud_fetch.sv
      - aud_pacer.sv
      - aud_mixer.sv
      - sd_dac.sv
      - aud_top.sv
  - target: simulation
    files:
      - tb_mem_model.sv
      - tb_aud_top.sv
